/* blit_top.f */
+incdir+dv
rtl/blit_pkg.sv
rtl/blit_stream_buf.sv
rtl/blit_raster.sv
rtl/blit_addr.sv
rtl/blit_fetch.sv
rtl/blit_fb_write.sv
rtl/blit_top.sv
dv/blit_axi_mem.sv
dv/blit_tb.sv

/* dv/blit_tb_util.svh */
// LCG step shared by the stimulus and the memory stalls
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Memory contents as a hash of the whole word address
function automatic logic [31:0] word_hash(input logic [29:0] word_addr);
    logic [31:0] h;
    h = {word_addr, 2'b00} ^ 32'h3c6e_f372;
    h = h * 32'h2545_f491;
    return h ^ (h >> 15);
endfunction

/* dv/blit_axi_mem.sv */
`timescale 1ns/1ps

module blit_axi_mem import blit_pkg::*; #(
    parameter logic [31:0] seed = 32'h9b55
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [addr_w-1:0] s_axil_araddr,
    input  logic              s_axil_arvalid,
    output logic              s_axil_arready = 1'b0,
    output logic [data_w-1:0] s_axil_rdata = '0,
    output logic              s_axil_rvalid = 1'b0,
    input  logic              s_axil_rready
);

    `include "blit_tb_util.svh"

    logic [31:0]       rng;
    logic [2:0]        delay; // Stall cycles before the next beat
    logic              busy;
    logic [addr_w-1:0] addr_q;

    always @(posedge clk) begin
        if (rst) begin
            rng <= seed;
            delay <= 3'd0;
            busy <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else if (!busy) begin
            if (s_axil_arready && s_axil_arvalid) begin
                s_axil_arready <= 1'b0;
                addr_q <= s_axil_araddr;
                busy <= 1'b1;
                delay <= rng[30:28];
                rng <= lcg_next(rng);
            end else if (s_axil_arvalid && !s_axil_arready) begin
                if (delay == 3'd0)
                    s_axil_arready <= 1'b1;
                else
                    delay <= delay - 3'd1;
            end
        end else if (!s_axil_rvalid) begin
            if (delay == 3'd0) begin
                s_axil_rvalid <= 1'b1;
                s_axil_rdata <= word_hash(addr_q[addr_w-1:2]);
            end else begin
                delay <= delay - 3'd1;
            end
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
            busy <= 1'b0;
            delay <= rng[30:28];
            rng <= lcg_next(rng);
        end
    end

endmodule

/* dv/blit_tb.sv */
`timescale 1ns/1ps

module blit_tb import blit_pkg::*; ();

    `include "blit_tb_util.svh"

    localparam int wait_limit = 20000;

    logic                clk = 1'b0;
    logic                rst;
    draw_cmd_t           cmd;
    logic                cmd_valid;
    logic                cmd_ready;
    logic [addr_w-1:0]   m_axil_araddr;
    logic                m_axil_arvalid;
    logic                m_axil_arready;
    logic [data_w-1:0]   m_axil_rdata;
    logic                m_axil_rvalid;
    logic                m_axil_rready;
    logic [coord_w-1:0]  fb_x;
    logic [coord_w-1:0]  fb_y;
    logic [colour_w-1:0] fb_colour;
    logic                fb_write;

    pixel_t      exp_q[$];   // Expected writes in raster order
    logic [29:0] ar_q[$];    // Expected read word addresses
    logic [31:0] rand_state;
    logic [29:0] last_word;
    logic        word_seen;
    logic        ar_open = 1'b0;
    int          exp_ar = 0;
    int          got_ar = 0;
    int          checks = 0;
    int          errors = 0;
    int          writes = 0;
    int          timeouts = 0;

    always #5 clk = !clk;

    blit_top i_dut (
        .clk, .rst, .cmd, .cmd_valid, .cmd_ready,
        .m_axil_araddr, .m_axil_arvalid, .m_axil_arready,
        .m_axil_rdata, .m_axil_rvalid, .m_axil_rready,
        .fb_x, .fb_y, .fb_colour, .fb_write
    );

    blit_axi_mem #(.seed(32'h9b55)) i_mem (
        .clk, .rst,
        .s_axil_araddr(m_axil_araddr), .s_axil_arvalid(m_axil_arvalid),
        .s_axil_arready(m_axil_arready), .s_axil_rdata(m_axil_rdata),
        .s_axil_rvalid(m_axil_rvalid), .s_axil_rready(m_axil_rready)
    );

    function automatic int next_rand(input int range);
        rand_state = lcg_next(rand_state);
        return int'(rand_state[30:8]) % range;
    endfunction

    task automatic check_value(input string name, input int exp, input int got);
        checks++;
        assert (exp == got) else begin
            errors++;
            $display("** Error at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        end
    endtask

    always @(posedge clk) begin
        pixel_t      e;
        logic [29:0] w;
        if (m_axil_rready === 1'b1)
            check_value("m_axil_rready", int'(ar_open), 1); // High only after the address phase
        if (m_axil_arvalid === 1'b1 && m_axil_arready === 1'b1) begin
            got_ar++;
            ar_open = 1'b1;
            if (ar_q.size() != 0) begin
                w = ar_q.pop_front();
                check_value("m_axil_araddr", int'({w, 2'b00}), int'(m_axil_araddr));
            end
        end
        if (m_axil_rvalid === 1'b1 && m_axil_rready === 1'b1)
            ar_open = 1'b0;
        if (fb_write === 1'b1) begin
            writes++;
            if (exp_q.size() == 0) begin
                check_value("fb_write", 0, 1); // Write beyond the model's list
            end else begin
                e = exp_q.pop_front();
                check_value("fb_x", int'(e.x), int'(fb_x));
                check_value("fb_y", int'(e.y), int'(fb_y));
                check_value("fb_colour", int'(e.colour), int'(fb_colour));
            end
        end
    end

    // Raster walk with upscaling, mirroring and per pixel clipping
    task automatic build_expected(input draw_cmd_t c);
        int                px;
        int                py;
        int                x;
        int                y;
        int                sx;
        int                sy;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] word;
        pixel_t            p;
        if (c.scale_x == '0 || c.scale_y == '0)
            return;
        for (py = 0; py < int'(c.height); py++) begin
            for (px = 0; px < int'(c.width); px++) begin
                x = c.mirror_x ? int'(c.screen_x) + int'(c.width) - 1 - px : int'(c.screen_x) + px;
                y = c.mirror_y ? int'(c.screen_y) + int'(c.height) - 1 - py : int'(c.screen_y) + py;
                if (x < fb_width && y < fb_height) begin
                    p.x = coord_w'(x);
                    p.y = coord_w'(y);
                    p.colour = c.colour;
                    if (c.colour_src == src_memory) begin
                        sx = int'(c.sprite_x) + px / int'(c.scale_x);
                        sy = int'(c.sprite_y) + py / int'(c.scale_y);
                        addr = c.sprite_base +
                               addr_w'((sy * int'(c.sprite_width) + sx) * bytes_per_pixel);
                        word = word_hash(addr[addr_w-1:2]);
                        p.colour = addr[1] ? word[31:16] : word[15:0];
                        if (!word_seen || last_word != addr[addr_w-1:2]) begin
                            exp_ar++; // Cache miss
                            ar_q.push_back(addr[addr_w-1:2]);
                        end
                        word_seen = 1'b1;
                        last_word = addr[addr_w-1:2];
                    end
                    exp_q.push_back(p);
                end
            end
        end
    endtask

    function automatic draw_cmd_t make_cmd(input int kind);
        draw_cmd_t c;
        c = '0;
        c.sprite_base = addr_w'(32'h1000 + 2 * next_rand(2048));
        c.sprite_width = coord_w'(64 + next_rand(64));
        c.sprite_x = coord_w'(next_rand(32));
        c.sprite_y = coord_w'(next_rand(32));
        c.screen_x = coord_w'(next_rand(fb_width - 32));
        c.screen_y = coord_w'(next_rand(fb_height - 24));
        c.width = coord_w'(1 + next_rand(24));
        c.height = coord_w'(1 + next_rand(16));
        c.scale_x = coord_w'(1);
        c.scale_y = coord_w'(1);
        c.colour_src = (kind == 1) ? src_colour : src_memory;
        c.colour = colour_w'(next_rand(65536));
        if (kind == 3 || kind == 5) begin
            c.scale_x = coord_w'((kind == 3 ? 2 : 1) + next_rand(kind == 3 ? 3 : 4));
            c.scale_y = coord_w'((kind == 3 ? 2 : 1) + next_rand(kind == 3 ? 3 : 4));
            c.mirror_x = next_rand(2) != 0;
            c.mirror_y = next_rand(2) != 0;
        end
        if (kind == 4) begin
            // Straddle the right and bottom edges
            c.screen_x = coord_w'(fb_width - 16 + next_rand(32));
            c.screen_y = coord_w'(fb_height - 12 + next_rand(24));
            c.mirror_x = next_rand(2) != 0;
        end
        if (kind == 4 || kind == 5)
            c.colour_src = next_rand(2) != 0 ? src_memory : src_colour;
        if (kind == 5) begin
            c.screen_x = coord_w'(next_rand(fb_width));
            c.screen_y = coord_w'(next_rand(fb_height));
        end
        return c;
    endfunction

    task automatic end_run();
        $display("checks %0d, writes %0d, errors %0d, timeouts %0d",
                 checks, writes, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (cmd_ready !== 1'b1 && n < wait_limit);
        if (cmd_ready !== 1'b1) begin
            timeouts++;
            $display("Timeout at %0t: cmd_ready stayed low while waiting for %s", $time, what);
        end
    endtask

    task automatic run_cmd(input draw_cmd_t c);
        build_expected(c);
        cmd <= c;
        cmd_valid <= 1'b1;
        wait_ready("command acceptance");
        cmd_valid <= 1'b0;
        if (timeouts == 0)
            wait_ready("command completion");
        if (timeouts == 0)
            check_value("pending writes", 0, exp_q.size());
        exp_q.delete();
    endtask

    task automatic run_test(input int id, input string name, input int kind, input int n_cmds);
        int        i;
        int        err0;
        draw_cmd_t c;
        err0 = errors;
        for (i = 0; i < n_cmds && timeouts == 0; i++) begin
            c = make_cmd(kind);
            if (kind == 4 && i % 4 == 3)
                c.scale_x = '0; // Empty command
            run_cmd(c);
        end
        check_value("ar handshakes", exp_ar, got_ar);
        $display("test %0d %s: %0d commands, %0d errors", id, name, i, errors - err0);
    endtask

    initial begin
        rst = 1'b1;
        cmd = '0;
        cmd_valid = 1'b0;
        rand_state = 32'h9b55;
        word_seen = 1'b0;
        last_word = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        run_test(1, "solid fill", 1, 6);
        run_test(2, "memory copy", 2, 6);
        run_test(3, "upscale and mirror", 3, 8);
        run_test(4, "clipping and empty", 4, 12);
        run_test(5, "random under stalls", 5, 30);
        end_run();
    end

endmodule

/* rtl/blit_addr.sv */
`timescale 1ns/1ps

module blit_addr import blit_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  image_t     image,
    input  src_pix_t   in_pix,
    input  logic       in_valid,
    output logic       in_ready,
    output fetch_req_t out_req,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       idle
);

    logic [addr_w-1:0] pix_index;
    logic [addr_w-1:0] byte_addr;
    logic              take;

    // Row major index into the sprite sheet
    assign pix_index = addr_w'(in_pix.src_y) * addr_w'(image.row_width) +
                       addr_w'(in_pix.src_x);
    assign byte_addr = image.base + pix_index * addr_w'(bytes_per_pixel);

    assign in_ready = !out_valid || out_ready;
    assign take = in_valid && in_ready;
    assign idle = !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_req.addr <= byte_addr;
            out_req.x <= in_pix.x;
            out_req.y <= in_pix.y;
        end
    end

endmodule

/* rtl/blit_fb_write.sv */
`timescale 1ns/1ps

module blit_fb_write import blit_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  pixel_t              fill_pix,
    input  logic                fill_valid,
    output logic                fill_ready,
    input  pixel_t              mem_pix,
    input  logic                mem_valid,
    output logic                mem_ready,
    output logic [coord_w-1:0]  fb_x,
    output logic [coord_w-1:0]  fb_y,
    output logic [colour_w-1:0] fb_colour,
    output logic                fb_write,
    output logic                idle
);

    logic   ready_q;
    logic   take;
    pixel_t sel_pix;

    assign fill_ready = ready_q;
    assign mem_ready = ready_q && !fill_valid; // Fill wins a tie
    assign take = ready_q && (fill_valid || mem_valid);
    assign sel_pix = fill_valid ? fill_pix : mem_pix;
    assign idle = ready_q && !fb_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            fb_write <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            fb_write <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fb_x <= sel_pix.x;
            fb_y <= sel_pix.y;
            fb_colour <= sel_pix.colour;
        end
    end

endmodule

/* rtl/blit_fetch.sv */
`timescale 1ns/1ps

module blit_fetch import blit_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  fetch_req_t        in_req,
    input  logic              in_valid,
    output logic              in_ready,
    output logic [addr_w-1:0] m_axil_araddr,
    output logic              m_axil_arvalid,
    input  logic              m_axil_arready,
    input  logic [data_w-1:0] m_axil_rdata,
    input  logic              m_axil_rvalid,
    output logic              m_axil_rready,
    output pixel_t            out_pix,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              idle
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_out
    } state_t;

    state_t            state;
    fetch_req_t        req_q;
    logic              cache_valid;
    logic [addr_w-3:0] cache_tag; // Word address of the cached word
    logic [data_w-1:0] cache_data;
    logic              hit;

    function automatic logic [colour_w-1:0] half_sel(input logic [data_w-1:0] word,
                                                     input logic              high);
        return high ? word[data_w-1 -: colour_w] : word[colour_w-1:0];
    endfunction

    assign in_ready = state == st_idle;
    assign idle = state == st_idle;
    assign hit = cache_valid && (cache_tag == in_req.addr[addr_w-1:2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cache_valid <= 1'b0;
            m_axil_arvalid <= 1'b0;
            m_axil_rready <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        if (hit) begin
                            out_valid <= 1'b1;
                            state <= st_out;
                        end else begin
                            m_axil_arvalid <= 1'b1;
                            state <= st_addr;
                        end
                    end
                end
                st_addr: begin
                    if (m_axil_arready) begin
                        m_axil_arvalid <= 1'b0;
                        m_axil_rready <= 1'b1;
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (m_axil_rvalid) begin
                        m_axil_rready <= 1'b0;
                        cache_valid <= 1'b1; // Refill completes with the data beat
                        out_valid <= 1'b1;
                        state <= st_out;
                    end
                end
                default: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && in_valid) begin
            req_q <= in_req;
            m_axil_araddr <= {in_req.addr[addr_w-1:2], 2'b00};
            out_pix.x <= in_req.x;
            out_pix.y <= in_req.y;
            out_pix.colour <= half_sel(cache_data, in_req.addr[1]);
        end
        if (state == st_data && m_axil_rvalid) begin
            cache_tag <= req_q.addr[addr_w-1:2];
            cache_data <= m_axil_rdata;
            out_pix.colour <= half_sel(m_axil_rdata, req_q.addr[1]);
        end
    end

endmodule

/* rtl/blit_pkg.sv */
package blit_pkg;

    localparam int coord_w = 16;
    localparam int colour_w = 16;
    localparam int addr_w = 32;
    localparam int data_w = 32;

    localparam int fb_width = 400;
    localparam int fb_height = 240;

    localparam int bytes_per_pixel = 2;

    typedef enum logic {
        src_colour,
        src_memory
    } colour_src_t;

    typedef struct packed {
        logic [addr_w-1:0]   sprite_base;
        logic [coord_w-1:0]  sprite_width; // Sheet row width in pixels
        logic [coord_w-1:0]  sprite_x;
        logic [coord_w-1:0]  sprite_y;
        logic [coord_w-1:0]  screen_x;
        logic [coord_w-1:0]  screen_y;
        logic [coord_w-1:0]  width;        // Screen rectangle size
        logic [coord_w-1:0]  height;
        logic [coord_w-1:0]  scale_x;      // Zero gives an empty command
        logic [coord_w-1:0]  scale_y;
        logic                mirror_x;
        logic                mirror_y;
        colour_src_t         colour_src;
        logic [colour_w-1:0] colour;
    } draw_cmd_t;

    typedef struct packed {
        logic [addr_w-1:0]  base;
        logic [coord_w-1:0] row_width;
    } image_t;

    typedef struct packed {
        logic [coord_w-1:0] src_x;
        logic [coord_w-1:0] src_y;
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
    } src_pix_t;

    typedef struct packed {
        logic [addr_w-1:0]  addr; // Byte address of the pixel
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
    } fetch_req_t;

    typedef struct packed {
        logic [coord_w-1:0]  x;
        logic [coord_w-1:0]  y;
        logic [colour_w-1:0] colour;
    } pixel_t;

endpackage

/* rtl/blit_raster.sv */
`timescale 1ns/1ps

module blit_raster import blit_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  draw_cmd_t cmd,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  logic      pipe_idle,
    output image_t    image,
    output src_pix_t  mem_pix,
    output logic      mem_valid,
    input  logic      mem_ready,
    output pixel_t    fill_pix,
    output logic      fill_valid,
    input  logic      fill_ready
);

    draw_cmd_t          cmd_q;
    logic               active;
    logic [coord_w-1:0] pos_x;
    logic [coord_w-1:0] pos_y;
    logic [coord_w-1:0] sub_x; // Repeat counters for upscaling
    logic [coord_w-1:0] sub_y;
    logic [coord_w-1:0] src_x;
    logic [coord_w-1:0] src_y;
    logic [coord_w-1:0] scr_x;
    logic [coord_w-1:0] scr_y;
    logic               on_screen;
    logic               is_mem;
    logic               cmd_fire;
    logic               step;
    logic               last_x;
    logic               last_y;

    assign cmd_ready = !active && pipe_idle;
    assign cmd_fire = cmd_valid && cmd_ready;

    always_comb begin
        if (cmd_q.mirror_x)
            scr_x = cmd_q.screen_x + cmd_q.width - coord_w'(1) - pos_x;
        else
            scr_x = cmd_q.screen_x + pos_x;
        if (cmd_q.mirror_y)
            scr_y = cmd_q.screen_y + cmd_q.height - coord_w'(1) - pos_y;
        else
            scr_y = cmd_q.screen_y + pos_y;
    end

    assign on_screen = (scr_x < coord_w'(fb_width)) && (scr_y < coord_w'(fb_height));
    assign is_mem = cmd_q.colour_src == src_memory;
    assign last_x = pos_x == cmd_q.width - coord_w'(1);
    assign last_y = pos_y == cmd_q.height - coord_w'(1);

    // Off-screen positions pass without a handshake
    assign step = active && (!on_screen || (is_mem ? mem_ready : fill_ready));

    assign mem_valid = active && on_screen && is_mem;
    assign fill_valid = active && on_screen && !is_mem;
    assign mem_pix = '{src_x: src_x, src_y: src_y, x: scr_x, y: scr_y};
    assign fill_pix = '{x: scr_x, y: scr_y, colour: cmd_q.colour};
    assign image = '{base: cmd_q.sprite_base, row_width: cmd_q.sprite_width};

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (cmd_fire) begin
            active <= (cmd.width != '0) && (cmd.height != '0) &&
                      (cmd.scale_x != '0) && (cmd.scale_y != '0);
        end else if (step && last_x && last_y) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            cmd_q <= cmd;
            pos_x <= '0;
            pos_y <= '0;
            sub_x <= '0;
            sub_y <= '0;
            src_x <= cmd.sprite_x;
            src_y <= cmd.sprite_y;
        end else if (step) begin
            if (last_x) begin
                pos_x <= '0;
                sub_x <= '0;
                src_x <= cmd_q.sprite_x;
                pos_y <= pos_y + coord_w'(1);
                if (sub_y == cmd_q.scale_y - coord_w'(1)) begin
                    sub_y <= '0;
                    src_y <= src_y + coord_w'(1);
                end else begin
                    sub_y <= sub_y + coord_w'(1);
                end
            end else begin
                pos_x <= pos_x + coord_w'(1);
                if (sub_x == cmd_q.scale_x - coord_w'(1)) begin
                    sub_x <= '0;
                    src_x <= src_x + coord_w'(1);
                end else begin
                    sub_x <= sub_x + coord_w'(1);
                end
            end
        end
    end

endmodule

/* rtl/blit_stream_buf.sv */
`timescale 1ns/1ps

module blit_stream_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready,
    output logic     idle
);

    payload_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready = count != 2'd2; // Drops only with both entries full
    assign out_valid = count != 2'd0;
    assign out_data = mem[rd_ptr];
    assign idle = count == 2'd0;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            if (push && !pop)
                count <= count + 2'd1;
            else if (pop && !push)
                count <= count - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

/* rtl/blit_top.sv */
`timescale 1ns/1ps

module blit_top import blit_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  draw_cmd_t           cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    output logic [addr_w-1:0]   m_axil_araddr,
    output logic                m_axil_arvalid,
    input  logic                m_axil_arready,
    input  logic [data_w-1:0]   m_axil_rdata,
    input  logic                m_axil_rvalid,
    output logic                m_axil_rready,
    output logic [coord_w-1:0]  fb_x,
    output logic [coord_w-1:0]  fb_y,
    output logic [colour_w-1:0] fb_colour,
    output logic                fb_write
);

    image_t     image;
    src_pix_t   rs_pix, ab_pix;
    logic       rs_valid, rs_ready, ab_valid, ab_ready;
    fetch_req_t ad_req, fb_req;
    logic       ad_valid, ad_ready, fq_valid, fq_ready;
    pixel_t     fe_pix, fill_pix;
    logic       fe_valid, fe_ready, fill_valid, fill_ready;
    logic       buf0_idle, addr_idle, buf1_idle, fetch_idle, wr_idle;
    logic       pipe_idle;

    assign pipe_idle = buf0_idle && addr_idle && buf1_idle && fetch_idle && wr_idle;

    blit_raster i_raster (
        .clk, .rst, .cmd, .cmd_valid, .cmd_ready, .pipe_idle, .image,
        .mem_pix(rs_pix), .mem_valid(rs_valid), .mem_ready(rs_ready),
        .fill_pix, .fill_valid, .fill_ready
    );

    blit_stream_buf #(.payload_t(src_pix_t)) i_pix_buf (
        .clk, .rst, .in_data(rs_pix), .in_valid(rs_valid), .in_ready(rs_ready),
        .out_data(ab_pix), .out_valid(ab_valid), .out_ready(ab_ready), .idle(buf0_idle)
    );

    blit_addr i_addr (
        .clk, .rst, .image, .in_pix(ab_pix), .in_valid(ab_valid), .in_ready(ab_ready),
        .out_req(ad_req), .out_valid(ad_valid), .out_ready(ad_ready), .idle(addr_idle)
    );

    blit_stream_buf #(.payload_t(fetch_req_t)) i_req_buf (
        .clk, .rst, .in_data(ad_req), .in_valid(ad_valid), .in_ready(ad_ready),
        .out_data(fb_req), .out_valid(fq_valid), .out_ready(fq_ready), .idle(buf1_idle)
    );

    blit_fetch i_fetch (
        .clk, .rst, .in_req(fb_req), .in_valid(fq_valid), .in_ready(fq_ready),
        .m_axil_araddr, .m_axil_arvalid, .m_axil_arready,
        .m_axil_rdata, .m_axil_rvalid, .m_axil_rready,
        .out_pix(fe_pix), .out_valid(fe_valid), .out_ready(fe_ready), .idle(fetch_idle)
    );

    blit_fb_write i_fb_write (
        .clk, .rst, .fill_pix, .fill_valid, .fill_ready,
        .mem_pix(fe_pix), .mem_valid(fe_valid), .mem_ready(fe_ready),
        .fb_x, .fb_y, .fb_colour, .fb_write, .idle(wr_idle)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the blitter testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module blit_tb \
    -f blit_top.f -o blit_sim > build.log 2>&1 ||
    { cat build.log; echo "build failed"; exit 1; }
./obj_dir/blit_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
